//--- hdl/ciCoprocessor.sv
// Custom instruction coprocessor top with reset sequencing, profiling counters and format unit
`timescale 1ns/1ps
`default_nettype none

module ciCoprocessor import ciPkg::*; #(
  parameter int NumCounters  = 4,
  parameter int CounterWidth = 32
) (
  input  wire          s_systemClock,
  input  wire          s_pllLocked,
  input  wire          ciStart,
  input  wire          stall,
  input  wire          busIdle,
  input  wire ciId_t   ciN,
  input  wire ciData_t ciValueA,
  input  wire ciData_t ciValueB,
  output logic         ciDone,
  output ciData_t      ciResult,
  output logic         sensorResetN
);

  logic                              coreReset;
  logic                              swapSelect;
  logic                              graySelect;
  logic                              profileSelect;
  logic [NumCounters-1:0]            counterSelect;
  logic [NumCounters-1:0]            counterEnable;
  logic [NumCounters-1:0]            counterDisable;
  logic [NumCounters-1:0]            counterClear;
  logic [NumCounters-1:0]            counterEvent;
  logic [NumCounters*CounterWidth-1:0] counterValues;
  logic                              formatDone;
  ciData_t                           formatResult;

  resetSequencer i_resetSequencer (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .coreReset     (coreReset),
    .sensorResetN  (sensorResetN)
  );

  ciDecoder #(
    .NumCounters (NumCounters)
  ) i_ciDecoder (
    .s_systemClock  (s_systemClock),
    .coreReset      (coreReset),
    .ciStart        (ciStart),
    .ciN            (ciN),
    .ciValueA       (ciValueA),
    .ciValueB       (ciValueB),
    .stall          (stall),
    .busIdle        (busIdle),
    .swapSelect     (swapSelect),
    .graySelect     (graySelect),
    .profileSelect  (profileSelect),
    .counterSelect  (counterSelect),
    .counterEnable  (counterEnable),
    .counterDisable (counterDisable),
    .counterClear   (counterClear),
    .counterEvent   (counterEvent)
  );

  // Counter bank, instruction 0x0B
  for (genvar i = 0; i < NumCounters; i++) begin : g_counter
    profileCounter #(
      .CounterWidth (CounterWidth)
    ) i_profileCounter (
      .s_systemClock (s_systemClock),
      .coreReset     (coreReset),
      .enable        (counterEnable[i]),
      .disableCount  (counterDisable[i]),
      .clear         (counterClear[i]),
      .countEvent    (counterEvent[i]),
      .readSelect    (counterSelect[i]),
      .count         (counterValues[i*CounterWidth +: CounterWidth])
    );
  end

  dataFormatIse i_dataFormatIse (
    .swapSelect   (swapSelect),
    .graySelect   (graySelect),
    .ciValueA     (ciValueA),
    .ciValueB     (ciValueB),
    .formatDone   (formatDone),
    .formatResult (formatResult)
  );

  ciResultMerge #(
    .NumCounters  (NumCounters),
    .CounterWidth (CounterWidth)
  ) i_ciResultMerge (
    .s_systemClock (s_systemClock),
    .coreReset     (coreReset),
    .profileSelect (profileSelect),
    .formatDone    (formatDone),
    .counterSelect (counterSelect),
    .counterValues (counterValues),
    .formatResult  (formatResult),
    .ciDone        (ciDone),
    .ciResult      (ciResult)
  );

endmodule

`default_nettype wire

//--- hdl/ciDecoder.sv
// Custom instruction decoder producing unit selects, counter controls and counter events
`timescale 1ns/1ps
`default_nettype none

module ciDecoder import ciPkg::*; #(
  parameter int NumCounters = 4
) (
  input  wire                     s_systemClock,
  input  wire                     coreReset,
  input  wire                     ciStart,
  input  wire ciId_t              ciN,
  input  wire ciData_t            ciValueA,
  input  wire ciData_t            ciValueB,
  input  wire                     stall,
  input  wire                     busIdle,
  output logic                    swapSelect,
  output logic                    graySelect,
  output logic                    profileSelect,
  output logic [NumCounters-1:0]  counterSelect,
  output logic [NumCounters-1:0]  counterEnable,
  output logic [NumCounters-1:0]  counterDisable,
  output logic [NumCounters-1:0]  counterClear,
  output logic [NumCounters-1:0]  counterEvent
);

  localparam int SelectBits = $clog2(MaxCounters);

  logic                   issue;
  logic [MaxCounters-1:0] eventSources;

  // No instruction is accepted while the core is held in reset
  assign issue         = ciStart & ~coreReset;
  assign swapSelect    = issue && (ciN == SwapByteId);
  assign graySelect    = issue && (ciN == GrayId);
  assign profileSelect = issue && (ciN == ProfileId);

  // Counter number in the low bits of operand A
  always_comb begin
    for (int i = 0; i < NumCounters; i++) begin
      counterSelect[i] = profileSelect && (ciValueA[SelectBits-1:0] == SelectBits'(i));
    end
  end

  // Cycles, stalls, idle bus, instruction starts
  assign eventSources = {ciStart, busIdle, stall, 1'b1};

  always_ff @(posedge s_systemClock or posedge coreReset) begin
    if (coreReset) begin
      counterEnable  <= '0;
      counterDisable <= '0;
      counterClear   <= '0;
      counterEvent   <= '0;
    end else begin
      counterEnable  <= profileSelect ? ciValueB[EnableField +: NumCounters] : '0;
      counterDisable <= profileSelect ? ciValueB[DisableField +: NumCounters] : '0;
      counterClear   <= profileSelect ? ciValueB[ClearField +: NumCounters] : '0;
      counterEvent   <= eventSources[NumCounters-1:0];
    end
  end

endmodule

`default_nettype wire

//--- hdl/ciPkg.sv
// Shared widths, instruction numbers and counter control fields of the custom-instruction unit
`default_nettype none

package ciPkg;

  // Operand and instruction number widths
  localparam int DataWidth = 32;
  localparam int CiIdWidth = 8;

  // Instruction numbers served behind the port
  localparam logic [CiIdWidth-1:0] SwapByteId = 8'h01;
  localparam logic [CiIdWidth-1:0] ProfileId  = 8'h0B;
  localparam logic [CiIdWidth-1:0] GrayId     = 8'h0C;

  // Top bit set after 16 locked cycles
  localparam int ResetCountBits = 5;

  // Each control field in operand B is four bits wide
  localparam int MaxCounters = 4;
  localparam int EnableField  = 0;
  localparam int DisableField = 4;
  localparam int ClearField   = 8;

  typedef logic [DataWidth-1:0] ciData_t;
  typedef logic [CiIdWidth-1:0] ciId_t;

endpackage

`default_nettype wire

//--- hdl/ciResultMerge.sv
// Merges unit responses into the registered custom instruction done and result
`timescale 1ns/1ps
`default_nettype none

module ciResultMerge import ciPkg::*; #(
  parameter int NumCounters  = 4,
  parameter int CounterWidth = 32
) (
  input  wire                                  s_systemClock,
  input  wire                                  coreReset,
  input  wire                                  profileSelect,
  input  wire                                  formatDone,
  input  wire [NumCounters-1:0]                counterSelect,
  input  wire [NumCounters*CounterWidth-1:0]   counterValues,
  input  wire ciData_t                         formatResult,
  output logic                                 ciDone,
  output ciData_t                              ciResult
);

  logic [CounterWidth-1:0] selectedCount;
  ciData_t                 profileResult;
  logic                    nextDone;
  ciData_t                 nextResult;

  // Select is one-hot, so OR-ing the masked counts is a mux
  always_comb begin
    selectedCount = '0;
    for (int i = 0; i < NumCounters; i++) begin
      if (counterSelect[i]) begin
        selectedCount = selectedCount | counterValues[i*CounterWidth +: CounterWidth];
      end
    end
  end

  assign profileResult = profileSelect ? DataWidth'(selectedCount) : '0;

  // Idle units drive zero
  assign nextDone   = profileSelect | formatDone;
  assign nextResult = profileResult | formatResult;

  always_ff @(posedge s_systemClock or posedge coreReset) begin
    if (coreReset) begin
      ciDone   <= 1'b0;
      ciResult <= '0;
    end else begin
      ciDone   <= nextDone;
      ciResult <= nextResult;
    end
  end

endmodule

`default_nettype wire

//--- hdl/dataFormatIse.sv
// Byte swap and RGB565 to grayscale custom instructions
`timescale 1ns/1ps
`default_nettype none

module dataFormatIse import ciPkg::*; (
  input  wire          swapSelect,
  input  wire          graySelect,
  input  wire ciData_t ciValueA,
  input  wire ciData_t ciValueB,
  output logic         formatDone,
  output ciData_t      formatResult
);

  ciData_t     swapped;
  logic [7:0]  red;
  logic [7:0]  green;
  logic [7:0]  blue;
  logic [15:0] weightedSum;

  // Bit 0 of B picks halfword-internal swap over full reversal
  assign swapped = ciValueB[0]
                 ? {ciValueA[23:16], ciValueA[31:24], ciValueA[7:0], ciValueA[15:8]}
                 : {ciValueA[7:0], ciValueA[15:8], ciValueA[23:16], ciValueA[31:24]};

  // Channels widened by plain left shift
  assign red   = {ciValueA[15:11], 3'b000};
  assign green = {ciValueA[10:5], 2'b00};
  assign blue  = {ciValueA[4:0], 3'b000};

  // Weights sum to 256, so the top byte is the gray level
  assign weightedSum = 16'd54 * red + 16'd183 * green + 16'd19 * blue;

  assign formatDone = swapSelect | graySelect;

  always_comb begin
    if (swapSelect) begin
      formatResult = swapped;
    end else if (graySelect) begin
      formatResult = {{(DataWidth-8){1'b0}}, weightedSum[15:8]};
    end else begin
      formatResult = '0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/profileCounter.sv
// Profiling event counter with enable, disable and clear control
`timescale 1ns/1ps
`default_nettype none

module profileCounter #(
  parameter int CounterWidth = 32
) (
  input  wire                     s_systemClock,
  input  wire                     coreReset,
  input  wire                     enable,
  input  wire                     disableCount,
  input  wire                     clear,
  input  wire                     countEvent,
  input  wire                     readSelect,
  output logic [CounterWidth-1:0] count
);

  logic running;
  logic runNow;

  // Enable and disable act in the cycle they arrive
  assign runNow = (running | enable) & ~disableCount;

  always_ff @(posedge s_systemClock or posedge coreReset) begin
    if (coreReset) begin
      running <= 1'b0;
      count   <= '0;
    end else begin
      running <= runNow;
      if (clear) begin
        count <= '0;
      end else if (runNow && countEvent) begin
        count <= count + 1'b1;
      end
    end
  end

  // readSelect goes to the result merger, which muxes this count out

endmodule

`default_nettype wire

//--- hdl/resetSequencer.sv
// Reset sequencer that holds the core in reset until the clock source has been locked a while
`timescale 1ns/1ps
`default_nettype none

module resetSequencer import ciPkg::*; (
  input  wire  s_systemClock,
  input  wire  s_pllLocked,
  output logic coreReset,
  output logic sensorResetN
);

  logic [ResetCountBits-1:0] resetCount;

  // Counts up after lock and parks once the top bit is set
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!resetCount[ResetCountBits-1]) begin
      resetCount <= resetCount + 1'b1;
    end
  end

  assign coreReset    = ~resetCount[ResetCountBits-1];
  assign sensorResetN = resetCount[ResetCountBits-1];

endmodule

`default_nettype wire

//--- runSim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module ciCoprocessorTb -f src.f -o ciCoprocessorSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ciCoprocessorSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Verification passed$" sim.log; then
  exit 0
fi
exit 1

//--- src.f
hdl/ciPkg.sv
hdl/resetSequencer.sv
hdl/ciDecoder.sv
hdl/profileCounter.sv
hdl/dataFormatIse.sv
hdl/ciResultMerge.sv
hdl/ciCoprocessor.sv
tests/ciCoprocessorTb.sv

//--- tests/ciCoprocessorTb.sv
// Directed testbench for the custom instruction coprocessor and its profiling counters
`timescale 1ns/1ps
`default_nettype none

module ciCoprocessorTb import ciPkg::*; ();

  localparam int NumCounters  = 4;
  localparam int CounterWidth = 32;
  localparam int ResetCycles  = 10;
  localparam int ResetRelease = 16;
  localparam int ResetTimeout = 40;
  localparam int DoneTimeout  = 8;
  localparam int BurstLength  = 6;

  logic        s_systemClock = 1'b0;
  logic        s_pllLocked;
  logic        ciStart;
  logic        stall;
  logic        busIdle;
  ciId_t       ciN;
  ciData_t     ciValueA;
  ciData_t     ciValueB;
  logic        ciDone;
  ciData_t     ciResult;
  logic        sensorResetN;
  int unsigned checkCount;
  int unsigned errorCount;
  logic [31:0] rngState;

  ciCoprocessor #(
    .NumCounters  (NumCounters),
    .CounterWidth (CounterWidth)
  ) i_ciCoprocessor (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .ciStart       (ciStart),
    .stall         (stall),
    .busIdle       (busIdle),
    .ciN           (ciN),
    .ciValueA      (ciValueA),
    .ciValueB      (ciValueB),
    .ciDone        (ciDone),
    .ciResult      (ciResult),
    .sensorResetN  (sensorResetN)
  );

  always #5 s_systemClock = ~s_systemClock;

  // Inputs change and outputs are sampled 1 ns after the rising edge
  task automatic nextCycle();
    @(posedge s_systemClock);
    #1;
  endtask

  function automatic logic [31:0] xorshift32();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  task automatic checkValue(input string testName, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("CHECK FAILED %s: expected %08h, actual %08h", testName, expected, actual);
    end
  endtask

  // Byte i moves to byte 3-i, or to its halfword neighbour in halfword mode
  function automatic logic [31:0] swapExpected(input logic [31:0] a, input logic halfwordMode);
    logic [31:0] swapped;
    swapped = '0;
    for (int i = 0; i < 4; i++) begin
      if (halfwordMode) begin
        swapped[8*(i^1) +: 8] = a[8*i +: 8];
      end else begin
        swapped[8*(3-i) +: 8] = a[8*i +: 8];
      end
    end
    return swapped;
  endfunction

  function automatic logic [31:0] grayExpected(input logic [15:0] pixel);
    int red;
    int green;
    int blue;
    red   = int'(pixel[15:11]) * 8;
    green = int'(pixel[10:5]) * 4;
    blue  = int'(pixel[4:0]) * 8;
    return 32'((54 * red + 183 * green + 19 * blue) / 256);
  endfunction

  // One start, then done is expected exactly one cycle later and only for one cycle
  task automatic issueInstruction(input string testName, input ciId_t id,
                                  input logic [31:0] a, input logic [31:0] b,
                                  input logic expectDone, input logic [31:0] expected);
    int cycles;
    ciStart  = 1'b1;
    ciN      = id;
    ciValueA = a;
    ciValueB = b;
    nextCycle();
    ciStart  = 1'b0;
    ciValueA = '0;
    ciValueB = '0;
    cycles   = 1;
    while (!ciDone && cycles < DoneTimeout) begin
      nextCycle();
      cycles++;
    end
    if (expectDone && !ciDone) begin
      errorCount++;
      $display("%s: no done within %0d cycles of the start", testName, DoneTimeout);
    end else if (expectDone) begin
      checkValue({testName, " latency"}, 32'd1, 32'(cycles));
      checkValue(testName, expected, ciResult);
      nextCycle();
      checkValue({testName, " done width"}, 32'd0, 32'(ciDone));
      checkValue({testName, " idle result"}, 32'd0, ciResult);
    end else if (ciDone) begin
      errorCount++;
      $display("%s: done returned although none was due", testName);
    end
  endtask

  task automatic resetReleaseTest();
    int lockCycles;
    repeat (ResetCycles) begin
      nextCycle();
      checkValue("reset sensorResetN", 32'd0, 32'(sensorResetN));
      checkValue("reset done", 32'd0, 32'(ciDone));
    end
    // A start right after lock must be ignored
    s_pllLocked = 1'b1;
    ciStart     = 1'b1;
    ciN         = SwapByteId;
    ciValueA    = xorshift32();
    lockCycles  = 0;
    while (!sensorResetN && lockCycles < ResetTimeout) begin
      nextCycle();
      ciStart = 1'b0;
      lockCycles++;
      checkValue("reset early start", 32'd0, 32'(ciDone));
    end
    checkValue("reset release cycles", 32'(ResetRelease), 32'(lockCycles));
    repeat (20) begin
      nextCycle();
      checkValue("reset idle done", 32'd0, 32'(ciDone));
      checkValue("reset idle result", 32'd0, ciResult);
    end
  endtask

  task automatic byteSwapTest();
    logic [31:0] a;
    logic [31:0] b;
    for (int i = 0; i < 8; i++) begin
      a    = xorshift32();
      b    = xorshift32();
      b[0] = i[0];
      issueInstruction($sformatf("byte swap mode %0d", b[0]), SwapByteId, a, b, 1'b1,
                       swapExpected(a, b[0]));
    end
  endtask

  task automatic grayscaleTest();
    logic [31:0] a;
    issueInstruction("gray red", GrayId, 32'h0000_f800, 32'd0, 1'b1, 32'd52);
    issueInstruction("gray green", GrayId, 32'h0000_07e0, 32'd0, 1'b1, 32'd180);
    issueInstruction("gray blue", GrayId, 32'h0000_001f, 32'd0, 1'b1, 32'd18);
    issueInstruction("gray white", GrayId, 32'h0000_ffff, 32'd0, 1'b1, 32'd250);
    // Upper operand bits are noise that the unit ignores
    for (int i = 0; i < 8; i++) begin
      a = xorshift32();
      issueInstruction("gray random", GrayId, a, xorshift32(), 1'b1, grayExpected(a[15:0]));
    end
  endtask

  task automatic profileCounterTest();
    int          stallCycles;
    int          idleCycles;
    int          swapCount;
    int          profilesBetween;
    logic [31:0] a;
    stallCycles     = 3 + int'(xorshift32() & 32'h7);
    idleCycles      = 2 + int'(xorshift32() & 32'h7);
    swapCount       = 3;
    profilesBetween = 1;
    issueInstruction("profile enable", ProfileId, 32'd1,
                     (32'he << ClearField) | (32'he << EnableField), 1'b1, 32'd0);
    stall = 1'b1;
    repeat (stallCycles) nextCycle();
    stall   = 1'b0;
    busIdle = 1'b1;
    repeat (idleCycles) nextCycle();
    busIdle = 1'b0;
    for (int i = 0; i < swapCount; i++) begin
      a = xorshift32();
      issueInstruction("profile window swap", SwapByteId, a, 32'd0, 1'b1, swapExpected(a, 1'b0));
    end
    // Counter 0 was never enabled
    issueInstruction("profile counter 0", ProfileId, 32'd0, 32'd0, 1'b1, 32'd0);
    issueInstruction("profile disable", ProfileId, 32'd0, 32'he << DisableField, 1'b1, 32'd0);
    stall   = 1'b1;
    busIdle = 1'b1;
    repeat (3) nextCycle();
    stall   = 1'b0;
    busIdle = 1'b0;
    issueInstruction("profile stall count", ProfileId, 32'd1, 32'd0, 1'b1, 32'(stallCycles));
    issueInstruction("profile idle count", ProfileId, 32'd2, 32'd0, 1'b1, 32'(idleCycles));
    issueInstruction("profile start count", ProfileId, 32'd3, 32'd0, 1'b1,
                     32'(swapCount + profilesBetween));
    issueInstruction("profile clear", ProfileId, 32'd1, 32'he << ClearField, 1'b1,
                     32'(stallCycles));
    for (int i = 1; i < NumCounters; i++) begin
      issueInstruction($sformatf("profile cleared %0d", i), ProfileId, 32'(i), 32'd0, 1'b1,
                       32'd0);
    end
  endtask

  task automatic unknownAndBurstTest();
    logic [31:0] a;
    logic [31:0] b;
    ciId_t       burstIds [BurstLength];
    logic [31:0] burstA [BurstLength];
    logic [31:0] burstB [BurstLength];
    logic [31:0] burstExpected [BurstLength];
    a = xorshift32();
    b = xorshift32();
    issueInstruction("unknown number", 8'h33, a, b, 1'b0, 32'd0);
    for (int i = 0; i < BurstLength; i++) begin
      burstA[i] = xorshift32();
      burstB[i] = xorshift32();
      if (i % 2 == 0) begin
        burstIds[i]      = SwapByteId;
        burstExpected[i] = swapExpected(burstA[i], burstB[i][0]);
      end else begin
        burstIds[i]      = GrayId;
        burstExpected[i] = grayExpected(burstA[i][15:0]);
      end
    end
    // Each response shows up while the next start is being driven
    for (int i = 0; i < BurstLength; i++) begin
      ciStart  = 1'b1;
      ciN      = burstIds[i];
      ciValueA = burstA[i];
      ciValueB = burstB[i];
      nextCycle();
      checkValue($sformatf("burst done %0d", i), 32'd1, 32'(ciDone));
      checkValue($sformatf("burst result %0d", i), burstExpected[i], ciResult);
    end
    ciStart = 1'b0;
    nextCycle();
    checkValue("burst trailing done", 32'd0, 32'(ciDone));
  endtask

  initial begin
    s_pllLocked = 1'b0;
    ciStart     = 1'b0;
    stall       = 1'b0;
    busIdle     = 1'b0;
    ciN         = '0;
    ciValueA    = '0;
    ciValueB    = '0;
    checkCount  = 0;
    errorCount  = 0;
    rngState    = 32'h7d19_56df;
    resetReleaseTest();
    byteSwapTest();
    grayscaleTest();
    profileCounterTest();
    unknownAndBurstTest();
    $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
